//--- hw/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// ******************************
// Datapath widths
// ******************************
// Load and store data word
`define LSU_DATA_W          32
// Byte lanes per data word
`define LSU_BYTE_W          4

// ******************************
// DCCM window
// ******************************
`define LSU_DCCM_BASE       32'hF004_0000
// Byte address bits inside the window, 4 KiB
`define LSU_DCCM_ADDR_BITS  12
// Word index width and RAM depth follow from the window size
`define LSU_DCCM_IDX_W      (`LSU_DCCM_ADDR_BITS - 2)
`define LSU_DCCM_WORDS      (1 << `LSU_DCCM_IDX_W)

// Store buffer entries, power of two so the pointers wrap on their own
`define LSU_SB_DEPTH        4
// Fill count must hold 0 up to LSU_SB_DEPTH
`define LSU_SB_CNT_W        3

`endif

//--- hw/lsu_pkg.sv
`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

   // ******************************
   // Request and pipeline types
   // ******************************

   // Decoded load/store request
   typedef struct packed {
      logic valid;                          // Request present
      logic load;
      logic store;
      logic by;                             // Byte access
      logic half;                           // Halfword access
      logic word;                           // Word access
      logic unsign;                         // Zero extend on load
   } lsu_pkt_t;

   // One dc stage of the pipeline
   typedef struct packed {
      lsu_pkt_t                 pkt;
      logic [31:0]              addr;       // Effective byte address
      logic [`LSU_DATA_W-1:0]   data;       // Store data already in its lanes
      logic [`LSU_BYTE_W-1:0]   be;         // Byte enables of the access
      logic                     exc;        // Misaligned or outside the DCCM
   } lsu_stage_t;

   // Exception report out of dc3
   typedef struct packed {
      logic        exc_valid;
      logic        is_store;
      logic        misaligned;              // Clear means access fault
      logic [31:0] addr;
   } lsu_error_pkt_t;

   // ******************************
   // Store buffer types
   // ******************************
   typedef struct packed {
      logic [`LSU_DCCM_IDX_W-1:0] idx;      // Word index inside the DCCM
      logic [`LSU_BYTE_W-1:0]     be;
      logic [`LSU_DATA_W-1:0]     data;
   } sb_entry_t;

   // Bytes forwarded to a load
   typedef struct packed {
      logic [`LSU_BYTE_W-1:0]     be;       // Lanes that override RAM data
      logic [`LSU_DATA_W-1:0]     data;
   } sb_fwd_t;

endpackage

`default_nettype wire

//--- hw/dccm_ram.sv
`default_nettype none

`include "lsu_cfg.svh"

module dccm_ram (
   input  logic                       clk,
   input  logic                       rd_en,
   input  logic [`LSU_DCCM_IDX_W-1:0] rd_idx,
   input  logic                       wr_en,
   input  logic [`LSU_DCCM_IDX_W-1:0] wr_idx,
   input  logic [`LSU_BYTE_W-1:0]     wr_be,     // Per lane write enable
   input  logic [`LSU_DATA_W-1:0]     wr_data,
   output logic [`LSU_DATA_W-1:0]     rd_data    // One cycle after rd_en
);

   logic [`LSU_DATA_W-1:0] mem [`LSU_DCCM_WORDS];

   // Byte lane writes
   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < `LSU_BYTE_W; b++) begin
            if (wr_be[b]) mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
         end
      end
   end

   // Registered read, same word write lands after it so old data returns
   always_ff @(posedge clk) begin
      if (rd_en) rd_data <= mem[rd_idx];
   end

endmodule

`default_nettype wire

//--- hw/lsu_lsc_ctl.sv
`default_nettype none

`include "lsu_cfg.svh"

module lsu_lsc_ctl (
   input  logic                     clk,
   input  logic                     rst_n,
   input  lsu_pkg::lsu_pkt_t        lsu_p,        // Request packet
   input  logic [31:0]              rs1,          // Base register
   input  logic [11:0]              offset,       // Signed immediate
   input  logic [`LSU_DATA_W-1:0]   store_data,   // Raw store operand
   input  logic [`LSU_SB_CNT_W-1:0] sb_count,     // Store buffer fill
   input  logic                     sb_empty,
   output lsu_pkg::lsu_stage_t      stage_dc1,
   output lsu_pkg::lsu_stage_t      stage_dc2,
   output lsu_pkg::lsu_error_pkt_t  error_pkt,
   output logic                     store_stall,
   output logic                     idle
);
   import lsu_pkg::*;

   localparam logic [31:0] dccm_base = `LSU_DCCM_BASE;
   localparam int          win_bits  = `LSU_DCCM_ADDR_BITS;
   localparam int          cnt_w     = `LSU_SB_CNT_W;

   logic [31:0]            addr_d;       // Effective address before dc1
   logic                   in_dccm_d;
   logic                   misaligned_d;
   logic [`LSU_BYTE_W-1:0] be_d;
   lsu_stage_t             stage_d;
   lsu_stage_t             stage_dc3;
   logic                   misaligned_dc3;

   // ******************************
   // Address generation and checks
   // ******************************
   assign addr_d = rs1 + {{20{offset[11]}}, offset};   // Sign extended offset

   // Upper bits select the DCCM window
   assign in_dccm_d = (addr_d[31:win_bits] == dccm_base[31:win_bits]);

   // Half on odd byte, word off a word boundary
   assign misaligned_d = (lsu_p.half & addr_d[0]) |
                         (lsu_p.word & (|addr_d[1:0]));

   always_comb begin
      if (lsu_p.word) begin
         be_d = '1;                                     // All four lanes
      end else if (lsu_p.half) begin
         be_d = 4'b0011 << addr_d[1:0];
      end else begin
         be_d = 4'b0001 << addr_d[1:0];                 // Single byte lane
      end
   end

   // Stage contents entering dc1
   always_comb begin
      stage_d.pkt  = lsu_p;
      stage_d.addr = addr_d;
      stage_d.data = lsu_p.store ? (store_data << {addr_d[1:0], 3'b000}) : '0;
      stage_d.be   = be_d;
      stage_d.exc  = ~in_dccm_d | misaligned_d;
   end

   // ******************************
   // dc1 to dc3 pipeline registers
   // ******************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         stage_dc1.pkt.valid <= 1'b0;     // Only the valids need clearing
         stage_dc2.pkt.valid <= 1'b0;
         stage_dc3.pkt.valid <= 1'b0;
      end else begin
         stage_dc1 <= stage_d;
         stage_dc2 <= stage_dc1;
         stage_dc3 <= stage_dc2;
      end
   end

   // Fault cause is recovered from the size and address in dc3
   assign misaligned_dc3 = (stage_dc3.pkt.half & stage_dc3.addr[0]) |
                           (stage_dc3.pkt.word & (|stage_dc3.addr[1:0]));

   // Exception report, one cycle pulse per faulting request
   always_comb begin
      error_pkt.exc_valid  = stage_dc3.pkt.valid & stage_dc3.exc;
      error_pkt.is_store   = stage_dc3.pkt.store;
      error_pkt.misaligned = misaligned_dc3;
      error_pkt.addr       = stage_dc3.addr;
   end

   // Two free entries kept for the stores in dc1 and dc2
   assign store_stall = (sb_count >= cnt_w'(`LSU_SB_DEPTH - 2));

   // Nothing in flight and nothing left to drain
   assign idle = ~(stage_dc1.pkt.valid | stage_dc2.pkt.valid | stage_dc3.pkt.valid) &
                 sb_empty;

   // Decode upstream must never send both kinds at once
   a_ld_st_excl: assert property (@(posedge clk) disable iff (!rst_n)
      lsu_p.valid |-> !(lsu_p.load && lsu_p.store));

endmodule

`default_nettype wire

//--- hw/lsu_stbuf.sv
`default_nettype none

`include "lsu_cfg.svh"

module lsu_stbuf (
   input  logic                     clk,
   input  logic                     rst_n,
   input  lsu_pkg::lsu_stage_t      stage_dc1,    // Load looking for forward data
   input  lsu_pkg::lsu_stage_t      stage_dc2,    // Store about to be pushed
   output lsu_pkg::sb_fwd_t         fwd_dc2,      // Forward bytes for the dc2 load
   output logic                     drain_valid,
   output lsu_pkg::sb_entry_t       drain_entry,
   output logic [`LSU_SB_CNT_W-1:0] sb_count,
   output logic                     sb_empty
);
   import lsu_pkg::*;

   localparam int depth = `LSU_SB_DEPTH;
   localparam int ptr_w = $clog2(`LSU_SB_DEPTH);
   localparam int cnt_w = `LSU_SB_CNT_W;

   sb_entry_t                  mem [depth];   // Entry storage, no reset
   logic [ptr_w-1:0]           head;          // Oldest entry
   logic [ptr_w-1:0]           tail;          // Next free slot
   logic                       push;
   logic                       pop;
   sb_entry_t                  push_entry;
   logic                       ld_dc1;
   logic [`LSU_DCCM_IDX_W-1:0] ld_idx_dc1;
   logic                       st_hit_dc2;
   sb_fwd_t                    fwd_d;

   // Overlay enabled bytes of one store onto the running forward value
   function automatic sb_fwd_t merge_bytes(sb_fwd_t acc,
                                           logic [`LSU_BYTE_W-1:0] be,
                                           logic [`LSU_DATA_W-1:0] data);
      sb_fwd_t r;
      r = acc;
      for (int b = 0; b < `LSU_BYTE_W; b++) begin
         if (be[b]) begin
            r.be[b]          = 1'b1;
            r.data[8*b +: 8] = data[8*b +: 8];   // Later call wins the lane
         end
      end
      return r;
   endfunction

   // ******************************
   // Push and drain
   // ******************************
   assign push = stage_dc2.pkt.valid & stage_dc2.pkt.store & ~stage_dc2.exc;

   always_comb begin
      push_entry.idx  = stage_dc2.addr[`LSU_DCCM_ADDR_BITS-1:2];
      push_entry.be   = stage_dc2.be;
      push_entry.data = stage_dc2.data;
   end

   assign sb_empty    = (sb_count == '0);
   assign pop         = ~sb_empty;               // Head leaves every cycle
   assign drain_valid = pop;
   assign drain_entry = mem[head];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         head     <= '0;
         tail     <= '0;
         sb_count <= '0;
      end else begin
         if (push) tail <= tail + 1'b1;
         if (pop)  head <= head + 1'b1;
         sb_count <= sb_count + cnt_w'(push) - cnt_w'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (push) mem[tail] <= push_entry;
   end

   // ******************************
   // Load forwarding in dc1
   // ******************************
   assign ld_dc1     = stage_dc1.pkt.valid & stage_dc1.pkt.load & ~stage_dc1.exc;
   assign ld_idx_dc1 = stage_dc1.addr[`LSU_DCCM_ADDR_BITS-1:2];
   assign st_hit_dc2 = push & (push_entry.idx == ld_idx_dc1);

   always_comb begin
      sb_entry_t        ent;
      logic [ptr_w-1:0] p;
      ent   = '0;
      p     = '0;
      fwd_d = '0;
      // Oldest to newest, the draining head included
      for (int i = 0; i < depth; i++) begin
         p   = head + ptr_w'(i);
         ent = mem[p];
         if (ld_dc1 && (i < sb_count) && (ent.idx == ld_idx_dc1)) begin
            fwd_d = merge_bytes(fwd_d, ent.be, ent.data);
         end
      end
      // Store in dc2 is newer than anything buffered
      if (ld_dc1 && st_hit_dc2) begin
         fwd_d = merge_bytes(fwd_d, push_entry.be, push_entry.data);
      end
   end

   always_ff @(posedge clk) begin
      fwd_dc2 <= fwd_d;                          // Lines up with RAM data in dc2
   end

   // Upstream stall must keep room for every accepted store
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      push |-> (sb_count < cnt_w'(depth)));

   a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
      sb_count <= cnt_w'(depth));

endmodule

`default_nettype wire

//--- hw/lsu_dccm_ctl.sv
`default_nettype none

`include "lsu_cfg.svh"

module lsu_dccm_ctl (
   input  logic                   clk,
   input  logic                   rst_n,
   input  lsu_pkg::lsu_stage_t    stage_dc1,     // Read issue stage
   input  lsu_pkg::lsu_stage_t    stage_dc2,     // Load finish stage
   input  lsu_pkg::sb_fwd_t       fwd_dc2,       // Buffered bytes for this load
   input  logic                   drain_valid,
   input  lsu_pkg::sb_entry_t     drain_entry,   // Store buffer head
   output logic                   result_valid,
   output logic [`LSU_DATA_W-1:0] result
);

   logic                       rd_en;
   logic [`LSU_DCCM_IDX_W-1:0] rd_idx;
   logic [`LSU_DATA_W-1:0]     rd_data;     // RAM word, valid in dc2
   logic                       ld_dc2;
   logic [`LSU_DATA_W-1:0]     merged;
   logic [`LSU_DATA_W-1:0]     shifted;
   logic [`LSU_DATA_W-1:0]     load_val;

   // ******************************
   // RAM access
   // ******************************
   assign rd_en  = stage_dc1.pkt.valid & stage_dc1.pkt.load & ~stage_dc1.exc;
   assign rd_idx = stage_dc1.addr[`LSU_DCCM_ADDR_BITS-1:2];

   dccm_ram i_dccm_ram (
      .clk     (clk),
      .rd_en   (rd_en),
      .rd_idx  (rd_idx),
      .wr_en   (drain_valid),
      .wr_idx  (drain_entry.idx),
      .wr_be   (drain_entry.be),
      .wr_data (drain_entry.data),
      .rd_data (rd_data)
   );

   // ******************************
   // Load alignment in dc2
   // ******************************
   assign ld_dc2 = stage_dc2.pkt.valid & stage_dc2.pkt.load & ~stage_dc2.exc;

   // Pending store bytes replace stale RAM lanes
   always_comb begin
      for (int b = 0; b < `LSU_BYTE_W; b++) begin
         merged[8*b +: 8] = fwd_dc2.be[b] ? fwd_dc2.data[8*b +: 8] : rd_data[8*b +: 8];
      end
   end

   assign shifted = merged >> {stage_dc2.addr[1:0], 3'b000};   // Access to lane 0

   // Size and sign handling
   always_comb begin
      if (stage_dc2.pkt.word) begin
         load_val = shifted;
      end else if (stage_dc2.pkt.half) begin
         load_val = stage_dc2.pkt.unsign ? {16'b0, shifted[15:0]} :
                                           {{16{shifted[15]}}, shifted[15:0]};
      end else begin
         load_val = stage_dc2.pkt.unsign ? {24'b0, shifted[7:0]} :
                                           {{24{shifted[7]}}, shifted[7:0]};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) result_valid <= 1'b0;
      else        result_valid <= ld_dc2;   // One pulse per good load
   end

   always_ff @(posedge clk) begin
      if (ld_dc2) result <= load_val;
   end

   // Every result comes from a load seen in dc2 the cycle before
   a_result_from_load: assert property (@(posedge clk) disable iff (!rst_n)
      result_valid |-> $past(stage_dc2.pkt.valid && stage_dc2.pkt.load));

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
`default_nettype none

`include "lsu_cfg.svh"

module lsu_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  lsu_pkg::lsu_pkt_t       lsu_p,
   input  logic [31:0]             rs1,
   input  logic [11:0]             offset,
   input  logic [`LSU_DATA_W-1:0]  store_data,
   output logic                    result_valid,
   output logic [`LSU_DATA_W-1:0]  result,
   output lsu_pkg::lsu_error_pkt_t error_pkt,
   output logic                    store_stall,
   output logic                    idle
);
   import lsu_pkg::*;

   lsu_stage_t               stage_dc1;
   lsu_stage_t               stage_dc2;
   sb_fwd_t                  fwd_dc2;
   logic                     drain_valid;
   sb_entry_t                drain_entry;   // Head entry headed for the RAM
   logic [`LSU_SB_CNT_W-1:0] sb_count;
   logic                     sb_empty;

   // Address, checks and pipeline
   lsu_lsc_ctl i_lsc_ctl (
      .clk, .rst_n, .lsu_p, .rs1, .offset, .store_data, .sb_count, .sb_empty,
      .stage_dc1, .stage_dc2, .error_pkt, .store_stall, .idle
   );

   // Store buffer with forwarding
   lsu_stbuf i_stbuf (
      .clk, .rst_n, .stage_dc1, .stage_dc2,
      .fwd_dc2, .drain_valid, .drain_entry, .sb_count, .sb_empty
   );

   // DCCM port and load result
   lsu_dccm_ctl i_dccm_ctl (
      .clk, .rst_n, .stage_dc1, .stage_dc2, .fwd_dc2, .drain_valid, .drain_entry,
      .result_valid, .result
   );

endmodule

`default_nettype wire

//--- sim/tb_lsu.sv
`default_nettype none

`include "lsu_cfg.svh"

module tb_lsu;
   import lsu_pkg::*;

   localparam logic [31:0] dccm_base   = `LSU_DCCM_BASE;
   localparam int          win_bytes   = 64;      // Test window at the DCCM base
   localparam int          n_random    = 3000;
   localparam int          stall_limit = 64;      // Cycles a store may wait
   localparam int          idle_limit  = 64;

   // Request as driven, target address kept for the model
   typedef struct packed {
      lsu_pkt_t               pkt;
      logic [31:0]            addr;
      logic [31:0]            rs1;
      logic [11:0]            offset;
      logic [`LSU_DATA_W-1:0] data;
   } req_t;

   // What dc3 must show for one presented cycle
   typedef struct packed {
      logic                   req_valid;   // Request occupies the pipeline
      logic                   sb_push;     // Good store entering the buffer
      logic                   res_valid;
      logic [`LSU_DATA_W-1:0] res;
      lsu_error_pkt_t         err;
   } exp_t;

   logic                   clk;
   logic                   rst_n;
   lsu_pkt_t               lsu_p;
   logic [31:0]            rs1;
   logic [11:0]            offset;
   logic [`LSU_DATA_W-1:0] store_data;
   logic                   result_valid;
   logic [`LSU_DATA_W-1:0] result;
   lsu_error_pkt_t         error_pkt;
   logic                   store_stall;
   logic                   idle;

   logic [7:0] model_mem [win_bytes];   // Byte model of the test window
   exp_t       exp_q [$];               // One entry per presented cycle
   integer     seed;
   logic [5:0] last_st_off;             // Window offset of the newest good store
   logic       last_st_ok;
   int         sb_model;                // Expected store buffer fill
   logic       stall_seen;              // Levels as they stood before the next edge
   logic       idle_seen;

   lsu_top i_lsu_top (
      .clk, .rst_n, .lsu_p, .rs1, .offset, .store_data,
      .result_valid, .result, .error_pkt, .store_stall, .idle
   );

   always #10 clk = ~clk;

   // ******************************
   // Error handling and compares
   // ******************************
   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("=== FAIL ===");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_result(input logic got_v, input logic [`LSU_DATA_W-1:0] got,
                               input logic want_v, input logic [`LSU_DATA_W-1:0] want);
      if (got_v !== want_v)
         stop_with_error($sformatf("FAIL t=%0t result_valid got %b exp %b",
                                   $time, got_v, want_v));
      else if (want_v && (got !== want))
         stop_with_error($sformatf("FAIL t=%0t result got %h exp %h", $time, got, want));
   endtask

   task automatic check_error(input lsu_error_pkt_t got, input lsu_error_pkt_t want);
      if (got.exc_valid !== want.exc_valid)
         stop_with_error($sformatf("FAIL t=%0t error_pkt.exc_valid got %b exp %b",
                                   $time, got.exc_valid, want.exc_valid));
      else if (want.exc_valid && (got !== want))   // Other fields only matter on a fault
         stop_with_error($sformatf("FAIL t=%0t error_pkt got %h exp %h", $time, got, want));
   endtask

   // Status levels, one bit each
   task automatic check_level(input string name, input logic got, input logic want);
      if (got !== want)
         stop_with_error($sformatf("FAIL t=%0t %s got %b exp %b", $time, name, got, want));
   endtask

   // ******************************
   // Reference model
   // ******************************
   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic in_window(input logic [31:0] a);
      return (a - dccm_base) < (32'd1 << `LSU_DCCM_ADDR_BITS);   // Below base wraps high
   endfunction

   function automatic logic is_misaligned(input req_t rq);
      return (rq.pkt.half && rq.addr[0]) || (rq.pkt.word && (rq.addr[1:0] != 2'b00));
   endfunction

   function automatic exp_t expect_for(input req_t rq);
      exp_t        e;
      logic [5:0]  o;
      logic [31:0] w;
      e = '0;
      e.req_valid = rq.pkt.valid;
      o = rq.addr[5:0];                        // Byte offset inside the test window
      if (rq.pkt.valid && (is_misaligned(rq) || !in_window(rq.addr))) begin
         e.err.exc_valid  = 1'b1;
         e.err.is_store   = rq.pkt.store;
         e.err.misaligned = is_misaligned(rq);
         e.err.addr       = rq.addr;
      end else if (rq.pkt.valid && rq.pkt.load) begin
         w = {model_mem[o + 6'd3], model_mem[o + 6'd2], model_mem[o + 6'd1], model_mem[o]};
         e.res_valid = 1'b1;
         if (rq.pkt.word)
            e.res = w;
         else if (rq.pkt.half)
            e.res = rq.pkt.unsign ? {16'b0, w[15:0]} : {{16{w[15]}}, w[15:0]};
         else
            e.res = rq.pkt.unsign ? {24'b0, w[7:0]} : {{24{w[7]}}, w[7:0]};
      end else if (rq.pkt.valid && rq.pkt.store) begin
         e.sb_push = 1'b1;                     // Joins the buffer as dc2 ends
      end
      return e;
   endfunction

   task automatic apply_store(input req_t rq);
      int n;
      n = rq.pkt.word ? 4 : (rq.pkt.half ? 2 : 1);
      for (int i = 0; i < n; i++) begin
         model_mem[rq.addr[5:0] + 6'(i)] = rq.data[8*i +: 8];   // Low operand bytes first
      end
   endtask

   // ******************************
   // Stimulus
   // ******************************
   // Drive one cycle at the current edge and queue what dc3 shows for it
   task automatic present(input req_t rq);
      exp_t e;
      e = expect_for(rq);
      lsu_p      <= rq.pkt;
      rs1        <= rq.rs1;
      offset     <= rq.offset;
      store_data <= rq.data;
      exp_q.push_back(e);
      if (rq.pkt.valid && rq.pkt.store && !e.err.exc_valid) begin
         apply_store(rq);                      // Model follows issue order
         last_st_off = rq.addr[5:0];
         last_st_ok  = 1'b1;
      end
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      present('0);
   endtask

   task automatic issue(input req_t rq);
      int waited;
      waited = 0;
      @(posedge clk);
      while (rq.pkt.store && stall_seen) begin   // Stores held back during stall
         present('0);
         waited++;
         if (waited > stall_limit)
            stop_with_error("Timeout: store_stall stayed high and a store could not issue");
         @(posedge clk);
      end
      present(rq);
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      repeat (3) idle_cycle();                 // Let the last request enter the pipeline
      while (!idle_seen) begin
         idle_cycle();
         n++;
         if (n > idle_limit)
            stop_with_error("Timeout: idle did not return after traffic stopped");
      end
   endtask

   // Offset is random, rs1 chosen so the sum lands on the target
   function automatic req_t make_req(input logic ld, input int size, input logic uns,
                                     input logic [31:0] a, input logic [31:0] d);
      req_t        r;
      logic [11:0] off;
      off          = 12'($random(seed));
      r            = '0;
      r.pkt.valid  = 1'b1;
      r.pkt.load   = ld;
      r.pkt.store  = !ld;
      r.pkt.by     = (size == 1);
      r.pkt.half   = (size == 2);
      r.pkt.word   = (size == 4);
      r.pkt.unsign = uns;
      r.addr       = a;
      r.offset     = off;
      r.rs1        = a - {{20{off[11]}}, off};
      r.data       = d;
      return r;
   endfunction

   function automatic logic [31:0] aligned_in_window(input int size);
      logic [5:0] o;
      o = 6'(rand_below(win_bytes));
      if (size == 4) o[1:0] = 2'b00;
      else if (size == 2) o[0] = 1'b0;
      return dccm_base + 32'(o);
   endfunction

   function automatic req_t random_req();
      int          cat;
      int          size;
      logic        ld;
      logic [5:0]  o;
      logic [31:0] a;
      if (rand_below(100) < 15) return '0;     // Idle cycle
      ld   = 1'(rand_below(2));
      cat  = rand_below(100);
      size = 1 << rand_below(3);
      if (cat < 10) begin                      // Misaligned, half or word only
         size = rand_below(2) ? 2 : 4;
         o    = 6'(rand_below(win_bytes));
         if (size == 2) o[0] = 1'b1;
         else o[1:0] = 2'(1 + rand_below(3));
         a = dccm_base + 32'(o);
      end else if (cat < 15) begin             // Aligned, just above or below the DCCM
         a = (rand_below(2) ? dccm_base + 32'h1000 : dccm_base - 32'h1000) +
             (32'(rand_below(4096)) & 32'h0000_0ffc);
      end else begin
         a = aligned_in_window(size);
         if (ld && last_st_ok && (rand_below(100) < 40))
            a[5:2] = last_st_off[5:2];         // Hit the word of the newest store
      end
      return make_req(ld, size, 1'(rand_below(2)), a, $random(seed));
   endfunction

   // dc3 of a request presented three edges back shows at this negedge
   always @(negedge clk) begin
      exp_t e;
      stall_seen = store_stall;
      idle_seen  = idle;
      if (rst_n && (exp_q.size() > 3)) begin
         e = exp_q.pop_front();
         check_result(result_valid, result, e.res_valid, e.res);
         check_error(error_pkt, e.err);
         // Fill after this edge, push from dc2 while the head drains
         sb_model = sb_model + (e.sb_push ? 1 : 0) - ((sb_model != 0) ? 1 : 0);
         check_level("store_stall", store_stall, sb_model >= (`LSU_SB_DEPTH - 2));
         // Queue front now holds dc2, then dc1
         check_level("idle", idle, !e.req_valid && !exp_q[0].req_valid &&
                                   !exp_q[1].req_valid && (sb_model == 0));
      end
   end

   initial begin
      int          sz;
      logic [31:0] a;
      seed        = 32'hdcc762df;
      clk         = 1'b0;
      rst_n       = 1'b0;
      lsu_p       = '0;
      rs1         = '0;
      offset      = '0;
      store_data  = '0;
      last_st_off = '0;
      last_st_ok  = 1'b0;
      sb_model    = 0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      // Known word in every word of the test window
      for (int i = 0; i < win_bytes; i += 4)
         issue(make_req(1'b0, 4, 1'b0, dccm_base + 32'(i), $random(seed)));
      // Store then word load of the same word, gap grows from one cycle
      for (int i = 0; i < 8; i++) begin
         sz = 1 << (i % 3);
         a  = aligned_in_window(sz);
         issue(make_req(1'b0, sz, 1'b0, a, $random(seed)));
         repeat (i / 2) idle_cycle();
         issue(make_req(1'b1, 4, 1'b0, {a[31:2], 2'b00}, '0));
      end
      // Back-to-back store burst
      for (int i = 0; i < 24; i++) begin
         sz = 1 << rand_below(3);
         issue(make_req(1'b0, sz, 1'b0, aligned_in_window(sz), $random(seed)));
      end
      for (int i = 0; i < n_random; i++) issue(random_req());
      wait_idle();
      // Final read-back of the whole window
      for (int i = 0; i < win_bytes; i += 4)
         issue(make_req(1'b1, 4, 1'b0, dccm_base + 32'(i), '0));
      wait_idle();
      idle_cycle();
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/lsu_pkg.sv
hw/dccm_ram.sv
hw/lsu_lsc_ctl.sv
hw/lsu_stbuf.sv
hw/lsu_dccm_ctl.sv
hw/lsu_top.sv
sim/tb_lsu.sv
